// ==== source/aes_pkg.sv ====
/*
 * aes_pkg: shared types and GF(2^8) arithmetic for the AES-128 core
 * S-box is computed from field inversion plus the affine transform
 */
package aes_pkg;

    // byte 0 of the AES byte string sits in bits [127:120]
    typedef logic [127:0] block_t;
    typedef logic [31:0]  word_t;

    localparam int NUM_ROUNDS = 10;

    // multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] prod;
        logic [7:0] x;
        prod = 8'h00;
        x    = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                prod = prod ^ x;
            x = xtime(x);
        end
        return prod;
    endfunction

    // a^254 is the inverse for nonzero a, and zero maps to zero
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] acc;
        logic [7:0] sq;
        acc = 8'h01;
        sq  = a;
        for (int i = 1; i < 8; i++)
        begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    function automatic logic [7:0] rotl8(input logic [7:0] a, input int n);
        return (a << n) | (a >> (8 - n));
    endfunction

    function automatic logic [7:0] sbox(input logic [7:0] a);
        logic [7:0] b;
        b = gf_inv(a);
        // affine step over the inverse
        return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
    endfunction

    // 01, 02, 04 .. 80, then 1b and 36 for rounds 9 and 10
    function automatic logic [7:0] rcon(input int round);
        logic [7:0] r;
        r = 8'h01;
        for (int i = 1; i < round; i++)
            r = xtime(r);
        return r;
    endfunction

    function automatic word_t sub_word(input word_t w);
        return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
    endfunction

endpackage

// ==== source/aes_stage_if.sv ====
/*
 * aes_stage_if: one valid/ready hop between pipeline stages
 * carrying the AES state and the round key that goes with it
 */
`timescale 1ns/1ps

interface aes_stage_if;
    import aes_pkg::*;

    logic   valid;
    logic   ready;
    block_t state;
    block_t round_key;

    modport source
    (
        output valid,
        output state,
        output round_key,
        input  ready
    );

    modport sink
    (
        input  valid,
        input  state,
        input  round_key,
        output ready
    );
endinterface

// ==== source/aes_key_schedule.sv ====
/*
 * aes_key_schedule: one step of the AES-128 key expansion
 */
`timescale 1ns/1ps

module aes_key_schedule #(
    parameter int ROUND = 1
) (
    input  aes_pkg::block_t key_in,
    output aes_pkg::block_t key_out
);
    import aes_pkg::*;

    word_t w0, w1, w2, w3;
    word_t temp;
    word_t n0, n1, n2, n3;

    assign {w0, w1, w2, w3} = key_in;

    // RotWord, SubWord, then rcon into the top byte
    assign temp = sub_word({w3[23:0], w3[31:24]}) ^ {rcon(ROUND), 24'h000000};

    assign n0 = w0 ^ temp;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    assign key_out = {n0, n1, n2, n3};
endmodule

// ==== source/aes_round.sv ====
/*
 * aes_round: combinational AES round
 * sub bytes, shift rows, optional mix columns, add round key
 */
`timescale 1ns/1ps

module aes_round #(
    parameter bit FINAL = 1'b0
) (
    input  aes_pkg::block_t state_in,
    input  aes_pkg::block_t round_key,
    output aes_pkg::block_t state_out
);
    import aes_pkg::*;

    logic [7:0] sb [16];
    logic [7:0] sr [16];
    logic [7:0] mc [16];
    block_t     mixed;

    always_comb
    begin
        for (int k = 0; k < 16; k++)
            sb[k] = sbox(state_in[127 - 8 * k -: 8]);

        // byte k is row k%4 of column k/4; row r rotates left by r columns
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                sr[4 * c + r] = sb[4 * ((c + r) % 4) + r];

        for (int c = 0; c < 4; c++)
        begin
            mc[4*c]   = xtime(sr[4*c]) ^ xtime(sr[4*c+1]) ^ sr[4*c+1] ^ sr[4*c+2] ^ sr[4*c+3];
            mc[4*c+1] = sr[4*c] ^ xtime(sr[4*c+1]) ^ xtime(sr[4*c+2]) ^ sr[4*c+2] ^ sr[4*c+3];
            mc[4*c+2] = sr[4*c] ^ sr[4*c+1] ^ xtime(sr[4*c+2]) ^ xtime(sr[4*c+3]) ^ sr[4*c+3];
            mc[4*c+3] = xtime(sr[4*c]) ^ sr[4*c] ^ sr[4*c+1] ^ sr[4*c+2] ^ xtime(sr[4*c+3]);
        end

        // last round skips mix columns
        for (int k = 0; k < 16; k++)
            mixed[127 - 8 * k -: 8] = FINAL ? sr[k] : mc[k];
    end

    assign state_out = mixed ^ round_key;
endmodule

// ==== source/aes_round_stage.sv ====
/*
 * aes_round_stage: one registered AES round with valid/ready handshake
 * expands its own round key from the key carried by the upstream hop
 */
`timescale 1ns/1ps

module aes_round_stage #(
    parameter int ROUND = 1
) (
    input logic        clk,
    input logic        rst_n,
    aes_stage_if.sink   up,
    aes_stage_if.source down
);
    import aes_pkg::*;

    logic   valid_q;
    block_t state_q;
    block_t key_q;
    block_t key_next;
    block_t state_next;

    aes_key_schedule #(.ROUND(ROUND)) u_key (
        .key_in  (up.round_key),
        .key_out (key_next)
    );

    aes_round #(.FINAL(ROUND == NUM_ROUNDS)) u_round (
        .state_in  (up.state),
        .round_key (key_next),
        .state_out (state_next)
    );

    // slot takes a new item when empty or draining this cycle
    assign up.ready = !valid_q || down.ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid_q <= 1'b0;
        else if (up.ready)
            valid_q <= up.valid;
    end

    always_ff @(posedge clk)
    begin
        if (up.valid && up.ready)
        begin
            state_q <= state_next;
            key_q   <= key_next;
        end
    end

    assign down.valid     = valid_q;
    assign down.state     = state_q;
    assign down.round_key = key_q;

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(down.valid));

    a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        down.valid && !down.ready |=> down.valid && $stable(down.state)
            && $stable(down.round_key));
endmodule

// ==== source/aes_input_stage.sv ====
/*
 * aes_input_stage: entry slot of the pipeline
 * registers plaintext xor key as the state and the key as round key
 */
`timescale 1ns/1ps

module aes_input_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  aes_pkg::block_t plaintext,
    input  aes_pkg::block_t key,
    aes_stage_if.source     out
);
    import aes_pkg::*;

    logic   valid_q;
    block_t state_q;
    block_t key_q;

    assign in_ready = !valid_q || out.ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid_q <= 1'b0;
        else if (in_ready)
            valid_q <= in_valid;
    end

    // initial add round key
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            state_q <= plaintext ^ key;
            key_q   <= key;
        end
    end

    assign out.valid     = valid_q;
    assign out.state     = state_q;
    assign out.round_key = key_q;

    a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out.valid && !out.ready |=> out.valid && $stable(out.state)
            && $stable(out.round_key));
endmodule

// ==== source/aes128_encrypt.sv ====
/*
 * aes128_encrypt: fully pipelined AES-128 encryption core
 * input slot plus ten round slots, one block per clock when not stalled
 */
`timescale 1ns/1ps

module aes128_encrypt (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  aes_pkg::block_t plaintext,
    input  aes_pkg::block_t key,
    output logic            out_valid,
    input  logic            out_ready,
    output aes_pkg::block_t ciphertext
);
    import aes_pkg::*;

    // hop[0] leaves the input stage, hop[r] leaves round r
    aes_stage_if hop [0:NUM_ROUNDS] ();

    aes_input_stage u_input (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .plaintext (plaintext),
        .key       (key),
        .out       (hop[0])
    );

    for (genvar g = 1; g <= NUM_ROUNDS; g++)
    begin : g_round
        aes_round_stage #(.ROUND(g)) u_stage (
            .clk   (clk),
            .rst_n (rst_n),
            .up    (hop[g-1]),
            .down  (hop[g])
        );
    end

    // final round key is not needed past the last stage
    assign out_valid            = hop[NUM_ROUNDS].valid;
    assign ciphertext           = hop[NUM_ROUNDS].state;
    assign hop[NUM_ROUNDS].ready = out_ready;
endmodule

// ==== verification/tb_clock_gen.sv ====
/*
 * tb_clock_gen: free-running testbench clock, 10 ns period
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);
    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end
endmodule

// ==== verification/aes_ref_model.svh ====
/*
 * reference AES-128 encryption for the testbench
 * S-box built by walking the multiplicative group of GF(2^8)
 */
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

logic [7:0] ref_sbox [0:255];

function automatic logic [7:0] ref_mul2(input logic [7:0] v);
    return (v << 1) ^ ({8{v[7]}} & 8'h1b);
endfunction

// p steps through the group by 3, q by the inverse of 3
task automatic build_ref_sbox();
    logic [7:0] p;
    logic [7:0] q;
    p = 8'h01;
    q = 8'h01;
    do
    begin
        p = p ^ (p << 1) ^ (p[7] ? 8'h1b : 8'h00);
        q = q ^ (q << 1);
        q = q ^ (q << 2);
        q = q ^ (q << 4);
        if (q[7])
            q = q ^ 8'h09;
        ref_sbox[p] = q ^ {q[6:0], q[7]} ^ {q[5:0], q[7:6]} ^ {q[4:0], q[7:5]}
            ^ {q[3:0], q[7:4]} ^ 8'h63;
    end
    while (p != 8'h01);
    ref_sbox[0] = 8'h63;
endtask

function automatic logic [127:0] ref_encrypt(input logic [127:0] pt, input logic [127:0] k);
    logic [7:0]   s [16];
    logic [7:0]   w [16];
    logic [7:0]   t [16];
    logic [7:0]   rc;
    logic [7:0]   tot;
    logic [127:0] res;
    for (int i = 0; i < 16; i++)
    begin
        w[i] = k[127 - 8 * i -: 8];
        s[i] = pt[127 - 8 * i -: 8] ^ w[i];
    end
    rc = 8'h01;
    for (int r = 1; r <= 10; r++)
    begin
        // next round key, in place
        w[0] = w[0] ^ ref_sbox[w[13]] ^ rc;
        w[1] = w[1] ^ ref_sbox[w[14]];
        w[2] = w[2] ^ ref_sbox[w[15]];
        w[3] = w[3] ^ ref_sbox[w[12]];
        for (int i = 4; i < 16; i++)
            w[i] = w[i] ^ w[i - 4];
        rc = ref_mul2(rc);
        // sub bytes and shift rows in one pass
        for (int i = 0; i < 16; i++)
            t[i] = ref_sbox[s[(i + 4 * (i % 4)) % 16]];
        for (int c = 0; c < 4; c++)
        begin
            tot = t[4*c] ^ t[4*c+1] ^ t[4*c+2] ^ t[4*c+3];
            s[4*c]   = (r == 10) ? t[4*c]   : t[4*c]   ^ tot ^ ref_mul2(t[4*c] ^ t[4*c+1]);
            s[4*c+1] = (r == 10) ? t[4*c+1] : t[4*c+1] ^ tot ^ ref_mul2(t[4*c+1] ^ t[4*c+2]);
            s[4*c+2] = (r == 10) ? t[4*c+2] : t[4*c+2] ^ tot ^ ref_mul2(t[4*c+2] ^ t[4*c+3]);
            s[4*c+3] = (r == 10) ? t[4*c+3] : t[4*c+3] ^ tot ^ ref_mul2(t[4*c+3] ^ t[4*c]);
        end
        for (int i = 0; i < 16; i++)
            s[i] = s[i] ^ w[i];
    end
    for (int i = 0; i < 16; i++)
        res[127 - 8 * i -: 8] = s[i];
    return res;
endfunction

`endif

// ==== verification/aes128_encrypt_tb.sv ====
/*
 * aes128_encrypt_tb drives the pipelined AES-128 core
 * and scores every output against a reference model
 */
`timescale 1ns/1ps

module aes128_encrypt_tb;
    localparam logic [127:0] KNOWN_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] KNOWN_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] KNOWN_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam int           TIMEOUT   = 1000;

    logic         clk;
    logic         rst_n      = 1'b0;
    logic         in_valid   = 1'b0;
    logic         in_ready;
    logic [127:0] plaintext  = '0;
    logic [127:0] key        = '0;
    logic         out_valid;
    logic         out_ready  = 1'b1;
    logic [127:0] ciphertext;

    integer seed       = 73459;
    // separate stream for out_ready
    integer ready_seed = 73460;

    logic [127:0] expected_q [$];
    logic [127:0] exp_ct;
    logic [127:0] held_ct;
    logic [127:0] last_ct;
    logic         held_stall   = 1'b0;
    logic         random_ready = 1'b0;
    int           n_in         = 0;
    int           n_out        = 0;
    int           cycle        = 0;
    int           in_cycle     = 0;
    int           out_cycle    = 0;
    int           full_count   = 0;
    int           stream_base  = -1;
    int           stream_first = 0;
    int           stream_last  = 0;

    `include "aes_ref_model.svh"

    tb_clock_gen u_clk (.clk(clk));

    aes128_encrypt u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .ciphertext (ciphertext)
    );

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("Fail at %0t: %s expected %h, got %h", $time, what, expected, actual);
        stop_on_failure();
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        stop_on_failure();
    endtask

    task automatic rand_block(output logic [127:0] value);
        value = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    // starts at a falling edge and returns at the falling edge after the transfer
    task automatic send_block(input logic [127:0] pt, input logic [127:0] k);
        int target;
        int waited;
        target    = n_in + 1;
        waited    = 0;
        in_valid  = 1'b1;
        plaintext = pt;
        key       = k;
        while (n_in < target)
        begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
                report_error("timed out waiting for the DUT to accept a block");
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (n_out != n_in)
        begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
                report_error("timed out waiting for the pipeline to drain");
        end
    endtask

    always @(negedge clk)
        out_ready <= random_ready ? ($random(ready_seed) % 2 == 0) : 1'b1;

    // input monitor, scoreboard and protocol checks on the rising edge
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            cycle = cycle + 1;
            if (!in_ready)
            begin
                full_count++;
                assert (n_in - n_out >= 11)
                else report_error("in_ready fell with fewer than eleven blocks pending");
            end
            if (held_stall)
            begin
                assert (out_valid && ciphertext == held_ct)
                else report_mismatch("ciphertext held under stall", held_ct, ciphertext);
            end
            if (in_valid && in_ready)
            begin
                expected_q.push_back(ref_encrypt(plaintext, key));
                n_in     = n_in + 1;
                in_cycle = cycle;
            end
            if (out_valid && out_ready)
            begin
                assert (expected_q.size() > 0)
                else report_error("output transfer with no block pending");
                exp_ct = expected_q.pop_front();
                assert (ciphertext == exp_ct)
                else report_mismatch("ciphertext", exp_ct, ciphertext);
                if (n_out == stream_base)
                    stream_first = cycle;
                if (n_out == stream_base + 199)
                    stream_last = cycle;
                last_ct   = ciphertext;
                out_cycle = cycle;
                n_out     = n_out + 1;
            end
            held_stall = out_valid && !out_ready;
            held_ct    = ciphertext;
        end
    end

    initial
    begin
        logic [127:0] pt;
        logic [127:0] k;
        build_ref_sbox();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (!out_valid && in_ready)
        else report_error("out_valid or in_ready wrong after reset");

        assert (ref_encrypt(KNOWN_PT, KNOWN_KEY) == KNOWN_CT)
        else report_mismatch("reference model", KNOWN_CT, ref_encrypt(KNOWN_PT, KNOWN_KEY));
        send_block(KNOWN_PT, KNOWN_KEY);
        in_valid = 1'b0;
        wait_drain();
        assert (last_ct == KNOWN_CT)
        else report_mismatch("known vector", KNOWN_CT, last_ct);

        // lone block latency
        rand_block(pt);
        rand_block(k);
        send_block(pt, k);
        in_valid = 1'b0;
        wait_drain();
        assert (out_cycle - in_cycle == 11)
        else report_mismatch("latency in cycles", 128'(11), 128'(out_cycle - in_cycle));

        stream_base = n_out;
        for (int i = 0; i < 200; i++)
        begin
            rand_block(pt);
            rand_block(k);
            send_block(pt, k);
        end
        in_valid = 1'b0;
        wait_drain();
        assert (stream_last - stream_first == 199)
        else report_mismatch("streaming output span", 128'(199),
                             128'(stream_last - stream_first));

        // random gaps on the input and random stalls on the output
        random_ready <= 1'b1;
        for (int i = 0; i < 200; i++)
        begin
            if ($random(seed) % 4 == 0)
            begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            rand_block(pt);
            rand_block(k);
            send_block(pt, k);
        end
        in_valid = 1'b0;
        random_ready <= 1'b0;
        wait_drain();
        assert (full_count > 0)
        else report_error("back-pressure never filled the pipeline");

        $display("Test passed");
        $finish;
    end
endmodule

// ==== aes128_encrypt.f ====
+incdir+verification
source/aes_pkg.sv
source/aes_stage_if.sv
source/aes_key_schedule.sv
source/aes_round.sv
source/aes_round_stage.sv
source/aes_input_stage.sv
source/aes128_encrypt.sv
verification/tb_clock_gen.sv
verification/aes128_encrypt_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the AES-128 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module aes128_encrypt_tb -f aes128_encrypt.f \
    -Mdir obj_dir -o sim_aes128 > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_aes128 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
